// File: design/aes_pkg.sv
`default_nettype none

package aes_pkg;

	typedef logic [7:0]   aes_byte_t;
	typedef logic [31:0]  aes_word_t;
	typedef logic [127:0] aes_block_t;
	typedef logic [127:0] aes_key_t;
	typedef logic [3:0]   aes_round_t;

	// multiply by x in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
	function automatic aes_byte_t xtime(aes_byte_t a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
		aes_byte_t p;
		aes_byte_t x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ x;
			x = xtime(x);
		end
		return p;
	endfunction

	// inverse as a^254, zero maps to zero
	function automatic aes_byte_t gf_inv(aes_byte_t a);
		aes_byte_t sq;
		aes_byte_t acc;
		sq = a;
		acc = 8'h01;
		for (int i = 1; i < 8; i++) begin
			sq = gf_mul(sq, sq);
			acc = gf_mul(acc, sq);
		end
		return acc;
	endfunction

	function automatic aes_byte_t rotl8(aes_byte_t a, int n);
		return (a << n) | (a >> (8 - n));
	endfunction

	// inversion followed by the affine map
	function automatic aes_byte_t sbox(aes_byte_t a);
		aes_byte_t b;
		b = gf_inv(a);
		return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
	endfunction

	function automatic aes_byte_t inv_sbox(aes_byte_t a);
		return gf_inv(rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05);
	endfunction

	function automatic aes_word_t swap_bytes32(aes_word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// buffer words are little-endian, cipher words big-endian
	function automatic aes_block_t swap_bytes128(aes_block_t b);
		aes_block_t r;
		for (int i = 0; i < 4; i++)
			r[127 - 32*i -: 32] = swap_bytes32(b[127 - 32*i -: 32]);
		return r;
	endfunction

endpackage

`default_nettype wire

// File: design/job_pkg.sv
`default_nettype none

package job_pkg;

	// host command codes
	typedef enum logic [31:0] {
		SET_KEY_128     = 32'd0,
		ECB_ENCRYPT_128 = 32'd1,
		ECB_DECRYPT_128 = 32'd2,
		CBC_ENCRYPT_128 = 32'd3,
		CBC_DECRYPT_128 = 32'd4
	} aes_cmd_t;

	// job sequencer states
	typedef enum logic [2:0] {
		IDLE           = 3'd0,
		INIT_BLOCK_RAM = 3'd1,
		GET_KEY        = 3'd2,
		GET_IV         = 3'd3,
		EXPAND_KEY     = 3'd4,
		PROCESS        = 3'd5
	} ctrl_state_t;

	// held by the host from en until done
	typedef struct packed {
		aes_cmd_t cmd;
		logic     skip_key_expansion;
	} job_cfg_t;

endpackage

`default_nettype wire

// File: design/aes_key_expand.sv
`timescale 1ns/100ps
`default_nettype none

module aes_key_expand (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,
	input  aes_pkg::aes_key_t   key,
	input  aes_pkg::aes_round_t round,
	output aes_pkg::aes_block_t round_key,
	output logic                done
);
	import aes_pkg::*;

	aes_block_t rk [11];
	aes_block_t last_key;
	aes_block_t next_key;
	aes_word_t  rot_word;
	aes_word_t  temp;
	aes_byte_t  rcon;
	aes_round_t cnt;

	// RotWord, SubWord and Rcon on the last word
	always_comb begin
		rot_word = {last_key[23:0], last_key[31:24]};
		temp = {sbox(rot_word[31:24]), sbox(rot_word[23:16]),
			sbox(rot_word[15:8]), sbox(rot_word[7:0])} ^ {rcon, 24'h000000};
		next_key[127:96] = last_key[127:96] ^ temp;
		next_key[95:64]  = last_key[95:64] ^ next_key[127:96];
		next_key[63:32]  = last_key[63:32] ^ next_key[95:64];
		next_key[31:0]   = last_key[31:0] ^ next_key[63:32];
	end

	// cnt is zero while idle
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				cnt <= 4'd1;
			end else if (cnt != 4'd0) begin
				if (cnt == 4'd10) begin
					cnt <= '0;
					done <= 1'b1;
				end else begin
					cnt <= cnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rk[0] <= key;
			last_key <= key;
			rcon <= 8'h01;
		end else if (cnt != 4'd0) begin
			rk[cnt] <= next_key;
			last_key <= next_key;
			rcon <= xtime(rcon);
		end
	end

	assign round_key = rk[round];

endmodule

`default_nettype wire

// File: design/aes_round_core.sv
`timescale 1ns/100ps
`default_nettype none

module aes_round_core (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,
	input  logic                decrypt,
	input  aes_pkg::aes_block_t in_blk,
	input  aes_pkg::aes_block_t round_key,
	output aes_pkg::aes_round_t round,
	output aes_pkg::aes_block_t out_blk,
	output logic                done
);
	import aes_pkg::*;

	aes_round_t cnt;
	aes_block_t state_q;
	aes_block_t enc_sr;
	aes_block_t enc_next;
	aes_block_t dec_ark;
	aes_block_t dec_next;
	logic       last;

	// byte i of the state sits at bits 127-8i, column major
	function automatic aes_block_t sub_bytes(aes_block_t b, logic inv);
		aes_block_t r;
		for (int i = 0; i < 16; i++)
			r[127 - 8*i -: 8] = inv ? inv_sbox(b[127 - 8*i -: 8]) : sbox(b[127 - 8*i -: 8]);
		return r;
	endfunction

	function automatic aes_block_t shift_rows(aes_block_t b, logic inv);
		aes_block_t r;
		int src;
		for (int c = 0; c < 4; c++) begin
			for (int row = 0; row < 4; row++) begin
				src = inv ? (c - row + 4) % 4 : (c + row) % 4;
				r[127 - 8*(4*c + row) -: 8] = b[127 - 8*(4*src + row) -: 8];
			end
		end
		return r;
	endfunction

	// one column times a circulant matrix given by its first row
	function automatic aes_word_t mix_word(aes_word_t w, aes_word_t m);
		aes_byte_t a [4];
		aes_word_t r;
		for (int i = 0; i < 4; i++)
			a[i] = w[31 - 8*i -: 8];
		for (int i = 0; i < 4; i++)
			r[31 - 8*i -: 8] = gf_mul(a[i], m[31:24]) ^ gf_mul(a[(i + 1) % 4], m[23:16]) ^
				gf_mul(a[(i + 2) % 4], m[15:8]) ^ gf_mul(a[(i + 3) % 4], m[7:0]);
		return r;
	endfunction

	function automatic aes_block_t mix_columns(aes_block_t b, logic inv);
		aes_block_t r;
		for (int c = 0; c < 4; c++)
			r[127 - 32*c -: 32] = inv ? mix_word(b[127 - 32*c -: 32], 32'h0e0b0d09) :
				mix_word(b[127 - 32*c -: 32], 32'h02030101);
		return r;
	endfunction

	assign last = (cnt == 4'd10);

	// forward round, no MixColumns in round 10
	assign enc_sr = shift_rows(sub_bytes(state_q, 1'b0), 1'b0);
	assign enc_next = (last ? enc_sr : mix_columns(enc_sr, 1'b0)) ^ round_key;

	// inverse round with the key added before InvMixColumns
	assign dec_ark = sub_bytes(shift_rows(state_q, 1'b1), 1'b1) ^ round_key;
	assign dec_next = last ? dec_ark : mix_columns(dec_ark, 1'b1);

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				cnt <= 4'd1;
			end else if (cnt != 4'd0) begin
				if (last) begin
					cnt <= '0;
					done <= 1'b1;
				end else begin
					cnt <= cnt + 4'd1;
				end
			end
		end
	end

	// initial key addition happens on start
	always_ff @(posedge clk) begin
		if (start)
			state_q <= in_blk ^ round_key;
		else if (cnt != 4'd0)
			state_q <= decrypt ? dec_next : enc_next;
	end

	assign round = cnt;
	assign out_blk = state_q;

endmodule

`default_nettype wire

// File: design/aes_top.sv
`timescale 1ns/100ps
`default_nettype none

module aes_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                en,
	input  job_pkg::aes_cmd_t   aes_cmd,
	input  aes_pkg::aes_key_t   aes_key,
	input  aes_pkg::aes_block_t aes_in_blk,
	output aes_pkg::aes_block_t aes_out_blk,
	output logic                en_o
);
	import aes_pkg::*;
	import job_pkg::*;

	aes_cmd_t   cmd_q;
	logic       ks_start;
	logic       ks_done;
	logic       core_start;
	logic       core_done;
	logic       decrypt;
	aes_round_t core_round;
	aes_round_t key_round;
	aes_block_t round_key;

	function automatic logic is_decrypt(aes_cmd_t cmd);
		return (cmd == ECB_DECRYPT_128) || (cmd == CBC_DECRYPT_128);
	endfunction

	always_ff @(posedge clk) begin
		if (reset)
			cmd_q <= SET_KEY_128;
		else if (en)
			cmd_q <= aes_cmd;
	end

	assign ks_start = en && (aes_cmd == SET_KEY_128);
	assign core_start = en && (aes_cmd != SET_KEY_128);

	// direction must be right already in the start cycle
	assign decrypt = en ? is_decrypt(aes_cmd) : is_decrypt(cmd_q);

	// decryption walks the round keys from 10 down to 0
	assign key_round = decrypt ? 4'd10 - core_round : core_round;

	aes_key_expand aes_key_expand_i (
		.clk       (clk),
		.reset     (reset),
		.start     (ks_start),
		.key       (aes_key),
		.round     (key_round),
		.round_key (round_key),
		.done      (ks_done)
	);

	aes_round_core aes_round_core_i (
		.clk       (clk),
		.reset     (reset),
		.start     (core_start),
		.decrypt   (decrypt),
		.in_blk    (aes_in_blk),
		.round_key (round_key),
		.round     (core_round),
		.out_blk   (aes_out_blk),
		.done      (core_done)
	);

	assign en_o = ks_done | core_done;

endmodule

`default_nettype wire

// File: design/block_ram.sv
`timescale 1ns/100ps
`default_nettype none

module block_ram #(
	parameter int ADDR_WIDTH = 9
) (
	input  logic                  clk,
	input  logic                  we,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  aes_pkg::aes_block_t   wr_data,
	input  logic                  rd_en,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output aes_pkg::aes_block_t   rd_data
);
	import aes_pkg::*;

	aes_block_t mem [2**ADDR_WIDTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// read data holds until the next rd_en
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: design/aes_controller.sv
`timescale 1ns/100ps
`default_nettype none

module aes_controller #(
	parameter int ADDR_WIDTH = 9
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  en,
	input  job_pkg::job_cfg_t     cfg,
	input  logic [ADDR_WIDTH-1:0] blk_cnt,
	input  aes_pkg::aes_block_t   rd_data,
	output logic                  rd_en,
	output logic [ADDR_WIDTH-1:0] rd_addr,
	output logic                  out_we,
	output logic [ADDR_WIDTH-1:0] out_addr,
	output logic [ADDR_WIDTH-1:0] out_blk_no,
	output aes_pkg::aes_block_t   out_data,
	output logic                  done
);
	import aes_pkg::*;
	import job_pkg::*;

	ctrl_state_t           state;
	aes_cmd_t              cmd_q;
	logic [ADDR_WIDTH-1:0] read_ptr;
	logic [ADDR_WIDTH-1:0] processed;
	logic                  last_read;
	logic                  core_start;
	logic                  core_done;
	logic                  is_cbc;
	logic                  is_cbc_enc;
	logic                  is_cbc_dec;
	aes_key_t              key_q;
	aes_block_t            iv_q;
	aes_block_t            prev_in;
	aes_block_t            buf_blk;
	aes_block_t            in_blk;
	aes_block_t            core_out;

	assign is_cbc_enc = (cmd_q == CBC_ENCRYPT_128);
	assign is_cbc_dec = (cmd_q == CBC_DECRYPT_128);
	assign is_cbc = is_cbc_enc || is_cbc_dec;

	assign last_read = (read_ptr == blk_cnt - 1'b1);
	assign rd_addr = read_ptr;

	// buffer word order to cipher word order
	assign buf_blk = swap_bytes128(rd_data);
	assign in_blk = is_cbc_enc ? (iv_q ^ buf_blk) : buf_blk;

	aes_top aes_top_i (
		.clk         (clk),
		.reset       (reset),
		.en          (core_start),
		.aes_cmd     (cmd_q),
		.aes_key     (key_q),
		.aes_in_blk  (in_blk),
		.aes_out_blk (core_out),
		.en_o        (core_done)
	);

	// the RAM is read one block ahead of the core
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			cmd_q <= SET_KEY_128;
			read_ptr <= '0;
			processed <= '0;
			core_start <= 1'b0;
			rd_en <= 1'b0;
			out_we <= 1'b0;
			out_addr <= '0;
			out_blk_no <= '0;
			done <= 1'b0;
		end else begin
			rd_en <= 1'b0;
			out_we <= 1'b0;
			done <= 1'b0;
			core_start <= 1'b0;
			case (state)
				IDLE: begin
					read_ptr <= '0;
					processed <= '0;
					if (en) begin
						cmd_q <= cfg.cmd;
						rd_en <= 1'b1;
						state <= INIT_BLOCK_RAM;
					end
				end
				INIT_BLOCK_RAM: begin
					out_blk_no <= '0;
					rd_en <= 1'b1;
					read_ptr <= read_ptr + 1'b1;
					// continuation job, whole buffer is payload
					if (cfg.skip_key_expansion) begin
						core_start <= 1'b1;
						state <= PROCESS;
					end else begin
						state <= GET_KEY;
					end
				end
				GET_KEY: begin
					cmd_q <= SET_KEY_128;
					processed <= processed + 1'b1;
					if (is_cbc) begin
						read_ptr <= read_ptr + 1'b1;
						rd_en <= 1'b1;
						state <= GET_IV;
					end else begin
						core_start <= 1'b1;
						state <= EXPAND_KEY;
					end
				end
				GET_IV: begin
					processed <= processed + 1'b1;
					core_start <= 1'b1;
					state <= EXPAND_KEY;
				end
				EXPAND_KEY: begin
					if (core_done) begin
						cmd_q <= cfg.cmd;
						rd_en <= 1'b1;
						core_start <= 1'b1;
						if (!last_read)
							read_ptr <= read_ptr + 1'b1;
						state <= PROCESS;
					end
				end
				PROCESS: begin
					if (core_start)
						processed <= processed + 1'b1;
					if (core_done) begin
						out_we <= 1'b1;
						out_addr <= out_blk_no;
						out_blk_no <= out_blk_no + 1'b1;
						rd_en <= 1'b1;
						core_start <= 1'b1;
						if (!last_read)
							read_ptr <= read_ptr + 1'b1;
						if (processed == blk_cnt) begin
							core_start <= 1'b0;
							rd_en <= 1'b0;
							done <= 1'b1;
							state <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// key and IV stay valid across jobs
	always_ff @(posedge clk) begin
		if (state == GET_KEY)
			key_q <= buf_blk;
		if (state == GET_IV)
			iv_q <= buf_blk;
		if (state == PROCESS && core_start)
			prev_in <= buf_blk;
		if (state == PROCESS && core_done) begin
			// CBC chaining
			if (is_cbc_enc)
				iv_q <= core_out;
			else if (is_cbc_dec)
				iv_q <= prev_in;
			out_data <= swap_bytes128(is_cbc_dec ? (iv_q ^ core_out) : core_out);
		end
	end

endmodule

`default_nettype wire

// File: design/aes_job_top.sv
`timescale 1ns/100ps
`default_nettype none

module aes_job_top #(
	parameter int ADDR_WIDTH = 9
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  en,
	input  job_pkg::job_cfg_t     cfg,
	input  logic [ADDR_WIDTH-1:0] blk_cnt,
	input  logic                  load_we,
	input  logic [ADDR_WIDTH-1:0] load_addr,
	input  aes_pkg::aes_block_t   load_data,
	output logic                  out_we,
	output logic [ADDR_WIDTH-1:0] out_addr,
	output logic [ADDR_WIDTH-1:0] out_blk_no,
	output aes_pkg::aes_block_t   out_data,
	output logic                  done
);
	import aes_pkg::*;

	logic                  rd_en;
	logic [ADDR_WIDTH-1:0] rd_addr;
	aes_block_t            rd_data;

	// host loads the job buffer while the engine is idle
	block_ram #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) block_ram_i (
		.clk     (clk),
		.we      (load_we),
		.wr_addr (load_addr),
		.wr_data (load_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	aes_controller #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) aes_controller_i (
		.clk        (clk),
		.reset      (reset),
		.en         (en),
		.cfg        (cfg),
		.blk_cnt    (blk_cnt),
		.rd_data    (rd_data),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.out_we     (out_we),
		.out_addr   (out_addr),
		.out_blk_no (out_blk_no),
		.out_data   (out_data),
		.done       (done)
	);

endmodule

`default_nettype wire

// File: verification/aes_job_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module aes_job_assertions (
	input logic                clk,
	input logic                reset,
	input job_pkg::ctrl_state_t state,
	input logic                out_we,
	input logic                done
);
	import job_pkg::*;

	int failures;

	initial failures = 0;

	a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			failures++;
		end

	// the last write lands in the first IDLE cycle, together with done
	a_we_idle: assert property (@(posedge clk) disable iff (reset)
		(state == IDLE && out_we) |-> done)
		else begin
			$error("out_we high in IDLE outside the final write");
			failures++;
		end

	a_reset_state: assert property (@(posedge clk)
		reset |=> (state == IDLE && !out_we && !done))
		else begin
			$error("controller not idle and quiet after reset");
			failures++;
		end

endmodule

bind aes_controller aes_job_assertions aes_job_assertions_i (
	.clk    (clk),
	.reset  (reset),
	.state  (state),
	.out_we (out_we),
	.done   (done)
);

`default_nettype wire

// File: verification/tb_aes_job.sv
`timescale 1ns/100ps
`default_nettype none

module tb_aes_job;
	import aes_pkg::*;
	import job_pkg::*;

	localparam int ADDR_WIDTH = 9;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int MAX_BLKS = 16;

	logic                  clk;
	logic                  reset;
	logic                  en;
	job_cfg_t              cfg;
	logic [ADDR_WIDTH-1:0] blk_cnt;
	logic                  load_we;
	logic [ADDR_WIDTH-1:0] load_addr;
	aes_block_t            load_data;
	logic                  out_we;
	logic [ADDR_WIDTH-1:0] out_addr;
	logic [ADDR_WIDTH-1:0] out_blk_no;
	aes_block_t            out_data;
	logic                  done;

	int errors;
	int checks;
	bit timed_out;

	// job as read from the vector file
	string      job_name;
	aes_cmd_t   job_cmd;
	logic       job_skip;
	int         job_blks;
	int         n_in;
	int         n_exp;
	aes_block_t in_blks [MAX_BLKS];
	aes_block_t exp_blks [MAX_BLKS];

	aes_job_top #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) aes_job_top_i (
		.clk        (clk),
		.reset      (reset),
		.en         (en),
		.cfg        (cfg),
		.blk_cnt    (blk_cnt),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.out_we     (out_we),
		.out_addr   (out_addr),
		.out_blk_no (out_blk_no),
		.out_data   (out_data),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic aes_cmd_t cmd_from_name(input string s);
		if (s == "ecb_enc")
			return ECB_ENCRYPT_128;
		if (s == "ecb_dec")
			return ECB_DECRYPT_128;
		if (s == "cbc_enc")
			return CBC_ENCRYPT_128;
		if (s == "cbc_dec")
			return CBC_DECRYPT_128;
		return SET_KEY_128;
	endfunction

	// key block, plus the IV block in CBC mode, unless the job continues
	function automatic int header_blocks(input aes_cmd_t cmd, input logic skip);
		if (skip)
			return 0;
		if (cmd == CBC_ENCRYPT_128 || cmd == CBC_DECRYPT_128)
			return 2;
		return 1;
	endfunction

	task automatic check_quiet();
		checks++;
		if (out_we !== 1'b0) begin
			$display("error: after_reset out_we expected 0 actual %b", out_we);
			errors++;
		end
		if (done !== 1'b0) begin
			$display("error: after_reset done expected 0 actual %b", done);
			errors++;
		end
	endtask

	task automatic read_record(input string tag, input int fd);
		int         c;
		int         skip;
		int         cnt;
		string      cmd_name;
		aes_block_t blk;
		aes_block_t expv;
		c = 0;
		if (tag == "#") begin
			// rest of the comment line
			c = $fgetc(fd);
			while (c != 10 && c != -1)
				c = $fgetc(fd);
		end else if (tag == "job") begin
			c = $fscanf(fd, "%s %s %d %d", job_name, cmd_name, skip, cnt);
			job_cmd = cmd_from_name(cmd_name);
			job_skip = (skip != 0);
			job_blks = cnt;
			n_in = 0;
			n_exp = 0;
			if (c != 4 || job_cmd == SET_KEY_128 || cnt < 1 || cnt > MAX_BLKS) begin
				$display("vector file has a bad job line for %s", job_name);
				errors++;
				job_blks = 0;
			end
		end else if ((tag == "h" || tag == "p") && n_in < job_blks) begin
			if (tag == "h") begin
				c = $fscanf(fd, "%h", blk);
				if (c != 1) begin
					$display("vector file has a bad header block line in %s", job_name);
					errors++;
				end
			end else begin
				c = $fscanf(fd, "%h %h", blk, expv);
				if (c != 2) begin
					$display("vector file has a bad payload block line in %s", job_name);
					errors++;
				end
				exp_blks[n_exp] = expv;
				n_exp++;
			end
			in_blks[n_in] = blk;
			n_in++;
		end else begin
			$display("vector file has a stray record %s", tag);
			errors++;
		end
	endtask

	task automatic load_buffer();
		for (int i = 0; i < n_in; i++) begin
			@(posedge clk);
			load_we <= 1'b1;
			load_addr <= ADDR_WIDTH'(i);
			load_data <= in_blks[i];
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	task automatic check_write(input int idx, input int n_writes);
		checks++;
		if (idx >= n_writes || idx >= n_exp) begin
			$display("%s gave write %0d beyond the %0d expected writes", job_name, idx + 1,
				n_writes);
			errors++;
		end else begin
			if (out_addr !== ADDR_WIDTH'(idx)) begin
				$display("error: %s out_addr expected %0d actual %0d", job_name, idx,
					out_addr);
				errors++;
			end
			if (out_blk_no !== ADDR_WIDTH'(idx + 1)) begin
				$display("error: %s out_blk_no expected %0d actual %0d", job_name, idx + 1,
					out_blk_no);
				errors++;
			end
			if (out_data !== exp_blks[idx]) begin
				$display("error: %s block %0d expected %h actual %h", job_name, idx + 1,
					exp_blks[idx], out_data);
				errors++;
			end
		end
	endtask

	task automatic run_job();
		int n_out;
		int n_writes;
		int cycles;
		bit finished;
		n_out = 0;
		cycles = 0;
		finished = 0;
		n_writes = job_blks - header_blocks(job_cmd, job_skip);
		if (n_exp != n_writes) begin
			$display("vector file lists %0d results for %0d payload blocks in %s", n_exp,
				n_writes, job_name);
			errors++;
		end
		@(posedge clk);
		cfg.cmd <= job_cmd;
		cfg.skip_key_expansion <= job_skip;
		blk_cnt <= ADDR_WIDTH'(job_blks);
		en <= 1'b1;
		@(posedge clk);
		en <= 1'b0;
		// outputs are sampled away from the rising edge
		while (!finished && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			if (out_we === 1'b1) begin
				check_write(n_out, n_writes);
				n_out++;
			end
			if (done === 1'b1) begin
				finished = 1;
				if (out_we !== 1'b1) begin
					$display("%s raised done without the last write", job_name);
					errors++;
				end
			end
		end
		if (!finished) begin
			$display("%s got no done within %0d cycles", job_name, TIMEOUT_CYCLES);
			errors++;
			timed_out = 1;
		end else if (n_out != n_writes) begin
			$display("error: %s write count expected %0d actual %0d", job_name, n_writes,
				n_out);
			errors++;
		end
	endtask

	initial begin
		int    fd;
		string tag;
		errors = 0;
		checks = 0;
		timed_out = 0;
		job_blks = 0;
		n_in = 0;
		n_exp = 0;
		reset = 1'b1;
		en = 1'b0;
		cfg = '0;
		blk_cnt = '0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// nothing moves before the first en
		repeat (4) begin
			@(negedge clk);
			check_quiet();
		end
		fd = $fopen("verification/aes_job_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/aes_job_vectors.txt");
			errors++;
		end else begin
			while (!timed_out && $fscanf(fd, "%s", tag) == 1) begin
				read_record(tag, fd);
				if (job_blks > 0 && n_in == job_blks) begin
					load_buffer();
					run_job();
					job_blks = 0;
				end
			end
			$fclose(fd);
		end
		errors += aes_job_top_i.aes_controller_i.aes_job_assertions_i.failures;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/aes_job_vectors.txt
# job <name> <cmd> <skip> <blk_cnt>, then one line per buffer block in address order
# h <key or IV block> | p <payload block> <expected result>, hex in buffer word order
job ecb_enc_fips197 ecb_enc 0 2
h 03020100070605040b0a09080f0e0d0c
p 3322110077665544bbaa9988ffeeddcc d8e0c46930047b6a80b7cdd85ac5b470
job ecb_dec_fips197 ecb_dec 0 2
h 03020100070605040b0a09080f0e0d0c
p d8e0c46930047b6a80b7cdd85ac5b470 3322110077665544bbaa9988ffeeddcc
job cbc_enc_sp800_38a cbc_enc 0 6
h 16157e2ba6d2ae288815f7ab3c4fcf09
h 03020100070605040b0a09080f0e0d0c
p e2bec16b969f402e117e3de92a179373 acab497646b219819b8ee9ce7d19e912
p 578a2dae9cac031eac6fb79e518eaf45 9bcb8650ee1972503a11db95b2787691
p 461cc83011e45ca319c1fbe5ef520a1a b8d6be733b74c1e39ee6167116952222
p 45249ff6179b4fdf7b412bad10376ce6 a1caf13f09ac1f6830ca0e12a7e18675
job cbc_dec_sp800_38a cbc_dec 0 6
h 16157e2ba6d2ae288815f7ab3c4fcf09
h 03020100070605040b0a09080f0e0d0c
p acab497646b219819b8ee9ce7d19e912 e2bec16b969f402e117e3de92a179373
p 9bcb8650ee1972503a11db95b2787691 578a2dae9cac031eac6fb79e518eaf45
p b8d6be733b74c1e39ee6167116952222 461cc83011e45ca319c1fbe5ef520a1a
p a1caf13f09ac1f6830ca0e12a7e18675 45249ff6179b4fdf7b412bad10376ce6
job cbc_enc_split_1 cbc_enc 0 4
h 16157e2ba6d2ae288815f7ab3c4fcf09
h 03020100070605040b0a09080f0e0d0c
p e2bec16b969f402e117e3de92a179373 acab497646b219819b8ee9ce7d19e912
p 578a2dae9cac031eac6fb79e518eaf45 9bcb8650ee1972503a11db95b2787691
job cbc_enc_split_2 cbc_enc 1 2
p 461cc83011e45ca319c1fbe5ef520a1a b8d6be733b74c1e39ee6167116952222
p 45249ff6179b4fdf7b412bad10376ce6 a1caf13f09ac1f6830ca0e12a7e18675

// File: build.f
design/aes_pkg.sv
design/job_pkg.sv
design/aes_key_expand.sv
design/aes_round_core.sv
design/aes_top.sv
design/block_ram.sv
design/aes_controller.sv
design/aes_job_top.sv
verification/aes_job_assertions.sv
verification/tb_aes_job.sv

// File: Bender.yml
package:
  name: aes_job

sources:
  - files:
      - design/aes_pkg.sv
      - design/job_pkg.sv
      - design/aes_key_expand.sv
      - design/aes_round_core.sv
      - design/aes_top.sv
      - design/block_ram.sv
      - design/aes_controller.sv
      - design/aes_job_top.sv
  - target: test
    files:
      - verification/aes_job_assertions.sv
      - verification/tb_aes_job.sv
